/* src.f */
src/bypass_pkg.sv
src/bypass_cam.sv
src/reg_file.sv
src/operand_fetch.sv
src/bypass_top.sv
testbench/tb_bypass_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_bypass_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/bypass_trace.txt */
# flush stall | int_wb valid addr value | fp_wb valid addr value | int_rd_addr 0 1 | fp_rd_addr 0 1 2
# expected hit value for int_operand 0 1, then fp_operand 0 1 2; all fields hex
0 0 0 00 0 0 00 0 01 02 00 01 02 0 0 0 0 0 0 0 0 0 0
0 0 0 00 0 0 00 0 1f 00 1f 10 03 0 0 0 0 0 0 0 0 0 0
0 0 1 05 101 1 03 f01 05 05 03 03 03 0 0 0 0 0 0 0 0 0 0
0 0 1 05 102 1 03 f02 05 06 03 00 03 1 101 0 0 1 f01 0 0 1 f01
0 0 1 06 201 1 00 f10 05 05 03 03 03 1 102 1 102 1 f02 1 f02 1 f02
0 0 1 00 bad 0 00 0 05 06 03 00 01 1 102 1 201 1 f02 1 f10 0 0
0 0 0 00 0 0 00 0 00 05 03 00 03 0 0 1 102 1 f02 1 f10 1 f02
0 0 0 00 0 0 00 0 05 06 03 00 02 0 102 1 201 0 f02 1 f10 0 0
0 0 1 00 abc 1 00 f11 06 00 00 03 00 0 201 0 0 0 f10 0 f02 0 f10
0 0 0 00 0 0 00 0 00 00 00 00 03 0 0 0 0 1 f11 1 f11 0 f02
0 0 0 00 0 0 00 0 00 06 00 01 02 0 0 0 201 1 f11 0 0 0 0
0 0 0 00 0 0 00 0 00 05 00 03 00 0 0 0 102 1 f11 0 f02 1 f11
0 0 0 05 999 0 03 999 00 00 00 00 00 0 0 0 0 0 f11 0 f11 0 f11
0 0 1 07 301 1 04 f21 07 05 04 03 00 0 0 0 102 0 0 0 f02 0 f11
0 0 1 08 302 1 05 f22 07 08 04 05 04 1 301 0 0 1 f21 0 0 1 f21
0 1 1 09 303 1 06 f23 07 08 04 05 06 1 301 1 302 1 f21 1 f22 0 0
0 1 1 07 3ff 1 04 f2f 07 09 04 06 05 1 301 0 0 1 f21 0 0 1 f22
0 0 1 09 304 1 06 f24 07 08 04 05 06 1 301 1 302 1 f21 1 f22 0 0
0 1 0 00 0 0 00 0 07 09 04 06 05 1 301 1 304 1 f21 1 f24 1 f22
0 1 0 00 0 0 00 0 07 08 04 05 06 1 301 1 302 1 f21 1 f22 1 f24
0 0 0 00 0 0 00 0 07 08 04 05 06 1 301 1 302 1 f21 1 f22 1 f24
0 0 0 00 0 0 00 0 07 09 04 06 05 0 301 1 304 0 f21 1 f24 1 f22
0 0 0 00 0 0 00 0 08 09 05 06 04 0 302 1 304 0 f22 1 f24 0 f21
0 0 0 00 0 0 00 0 09 07 06 05 04 0 304 0 301 0 f24 0 f22 0 f21
0 0 1 05 501 1 03 f51 05 05 03 03 03 0 102 0 102 0 f02 0 f02 0 f02
0 0 1 06 502 1 00 f52 05 06 03 00 03 1 501 0 201 1 f51 0 f11 1 f51
0 0 1 07 503 1 04 f53 05 06 03 00 04 1 501 1 502 1 f51 1 f52 0 f21
1 0 1 08 504 1 05 f54 05 07 03 00 04 1 501 1 503 1 f51 1 f52 1 f53
0 0 0 00 0 0 00 0 05 08 03 05 00 0 102 0 302 0 f02 0 f22 0 f11
0 0 0 00 0 0 00 0 06 07 00 04 05 0 201 0 301 0 f11 0 f21 0 f22
0 0 1 0a 601 1 07 f61 0a 05 07 03 00 0 0 0 102 0 0 0 f02 0 f11
0 0 1 0b 602 1 08 f62 0a 0b 07 08 07 1 601 0 0 1 f61 0 0 1 f61
1 1 1 0c 603 1 09 f63 0a 0b 07 08 09 1 601 1 602 1 f61 1 f62 0 0
0 0 0 00 0 0 00 0 0a 0b 07 08 09 0 0 0 0 0 0 0 0 0 0
0 0 1 0a 701 1 07 f71 0c 0a 09 07 08 0 0 0 0 0 0 0 0 0 0
0 0 1 1f 89abcdef 1 1f fedcba9876543210 0a 0a 07 07 07 1 701 1 701 1 f71 1 f71 1 f71
0 0 0 00 0 0 00 0 1f 0a 1f 1f 07 1 89abcdef 1 701 1 fedcba9876543210 1 fedcba9876543210 1 f71
0 0 0 00 0 0 00 0 1f 1f 1f 07 1f 1 89abcdef 1 89abcdef 1 fedcba9876543210 1 f71 1 fedcba9876543210
0 0 0 00 0 0 00 0 0a 1f 07 1f 1f 0 701 1 89abcdef 0 f71 1 fedcba9876543210 1 fedcba9876543210
0 0 0 00 0 0 00 0 1f 0a 1f 07 1f 0 89abcdef 0 701 0 fedcba9876543210 0 f71 0 fedcba9876543210
1 0 0 00 0 0 00 0 05 06 00 03 06 0 102 0 201 0 f11 0 f02 0 f24
0 0 0 00 0 0 00 0 1f 07 1f 04 05 0 89abcdef 0 301 0 fedcba9876543210 0 f21 0 f22

/* testbench/tb_bypass_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand fetch network testbench
// Replays a cycle trace into the DUT and compares every
// operand port against the expected hit and value
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_bypass_top;
    import bypass_pkg::*;

    localparam int    CLK_PERIOD   = 10;
    localparam int    RESET_CYCLES = 3;
    localparam int    BYPASS_DEPTH = 3;
    localparam int    NUM_FIELDS   = 8 + 3 * (int_read_ports + fp_read_ports);
    localparam string TRACE_FILE   = "testbench/bypass_trace.txt";

    // One trace line: inputs for the cycle and the operands expected before the edge
    typedef struct packed {
        logic                                  flush;
        logic                                  stall;
        int_wb_t                               int_wb;
        fp_wb_t                                fp_wb;
        reg_addr_t    [int_read_ports-1:0]     int_addr;
        reg_addr_t    [fp_read_ports-1:0]      fp_addr;
        int_operand_t [int_read_ports-1:0]     int_exp;
        fp_operand_t  [fp_read_ports-1:0]      fp_exp;
    } trace_row_t;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         stall;
    int_wb_t      int_wb;
    fp_wb_t       fp_wb;
    reg_addr_t    int_rd_addr [int_read_ports];
    reg_addr_t    fp_rd_addr [fp_read_ports];
    int_operand_t int_operand [int_read_ports];
    fp_operand_t  fp_operand [fp_read_ports];

    trace_row_t rows [$];
    int         check_errors;
    int         trace_errors;
    bit         trace_ready;

    bypass_top #(
        .BYPASS_DEPTH (BYPASS_DEPTH)
    ) u_bypass_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .stall       (stall),
        .int_wb      (int_wb),
        .fp_wb       (fp_wb),
        .int_rd_addr (int_rd_addr),
        .fp_rd_addr  (fp_rd_addr),
        .int_operand (int_operand),
        .fp_operand  (fp_operand)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic drive_idle();
        flush  = 1'b0;
        stall  = 1'b0;
        int_wb = '0;
        fp_wb  = '0;
        for (int p = 0; p < int_read_ports; p++) begin
            int_rd_addr[p] = '0;
        end
        for (int p = 0; p < fp_read_ports; p++) begin
            fp_rd_addr[p] = '0;
        end
    endtask

    // Comment lines start with '#', every other line holds NUM_FIELDS hex fields
    task automatic load_trace();
        int          fd;
        int          line_no;
        int          count;
        int          base;
        string       line;
        logic [63:0] f [NUM_FIELDS];
        trace_row_t  row;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open trace file %s", TRACE_FILE);
            trace_errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            line_no++;
            if (line.len() <= 1 || line.getc(0) == "#") continue;
            count = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                f[21], f[22]);
            if (count != NUM_FIELDS) begin
                $display("Error: trace line %0d has %0d fields where %0d are needed",
                         line_no, count, NUM_FIELDS);
                trace_errors++;
                continue;
            end
            row.flush        = f[0][0];
            row.stall        = f[1][0];
            row.int_wb.valid = f[2][0];
            row.int_wb.addr  = f[3][4:0];
            row.int_wb.value = f[4][31:0];
            row.fp_wb.valid  = f[5][0];
            row.fp_wb.addr   = f[6][4:0];
            row.fp_wb.value  = f[7];
            for (int p = 0; p < int_read_ports; p++) begin
                row.int_addr[p] = f[8 + p][4:0];
            end
            for (int p = 0; p < fp_read_ports; p++) begin
                row.fp_addr[p] = f[8 + int_read_ports + p][4:0];
            end
            base = 8 + int_read_ports + fp_read_ports;
            for (int p = 0; p < int_read_ports; p++) begin
                row.int_exp[p].hit   = f[base + 2 * p][0];
                row.int_exp[p].value = f[base + 2 * p + 1][31:0];
            end
            base = base + 2 * int_read_ports;
            for (int p = 0; p < fp_read_ports; p++) begin
                row.fp_exp[p].hit   = f[base + 2 * p][0];
                row.fp_exp[p].value = f[base + 2 * p + 1];
            end
            rows.push_back(row);
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            $display("Error: trace file holds no stimulus lines");
            trace_errors++;
        end
    endtask

    task automatic apply_row(input trace_row_t row);
        flush  = row.flush;
        stall  = row.stall;
        int_wb = row.int_wb;
        fp_wb  = row.fp_wb;
        for (int p = 0; p < int_read_ports; p++) begin
            int_rd_addr[p] = row.int_addr[p];
        end
        for (int p = 0; p < fp_read_ports; p++) begin
            fp_rd_addr[p] = row.fp_addr[p];
        end
    endtask

    task automatic check_int_operand(input int idx, input int port,
                                     input int_operand_t expected, input int_operand_t actual);
        if (actual !== expected) begin
            $display("[FAIL] row %0d int_operand[%0d]: expected hit=%h value=%h, got hit=%h value=%h",
                     idx, port, expected.hit, expected.value, actual.hit, actual.value);
            check_errors++;
        end
    endtask

    task automatic check_fp_operand(input int idx, input int port,
                                    input fp_operand_t expected, input fp_operand_t actual);
        if (actual !== expected) begin
            $display("[FAIL] row %0d fp_operand[%0d]: expected hit=%h value=%h, got hit=%h value=%h",
                     idx, port, expected.hit, expected.value, actual.hit, actual.value);
            check_errors++;
        end
    endtask

    task automatic check_row(input int idx, input trace_row_t row);
        for (int p = 0; p < int_read_ports; p++) begin
            check_int_operand(idx, p, row.int_exp[p], int_operand[p]);
        end
        for (int p = 0; p < fp_read_ports; p++) begin
            check_fp_operand(idx, p, row.fp_exp[p], fp_operand[p]);
        end
    endtask

    initial begin
        drive_idle();
        rst_n        = 1'b0;
        check_errors = 0;
        trace_errors = 0;
        trace_ready  = 1'b0;
        load_trace();
        trace_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            apply_row(rows[i]);
            // Sample just ahead of the rising edge
            #(CLK_PERIOD / 2 - 1);
            check_row(i, rows[i]);
        end
        $display("Report: %0d check errors, %0d trace errors over %0d trace rows",
                 check_errors, trace_errors, rows.size());
        if (check_errors == 0 && trace_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget of two clock periods per trace row plus some slack
    initial begin : watchdog
        int limit_ns;
        wait (trace_ready);
        limit_ns = (rows.size() + 10) * 2 * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: simulation still running after %0d ns", limit_ns);
        $display("Checks failed");
        $finish;
    end

endmodule

/* src/bypass_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand fetch network top level
// Integer and floating-point operand fetch units
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module bypass_top #(
    parameter int BYPASS_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     stall,
    input  bypass_pkg::int_wb_t      int_wb,
    input  bypass_pkg::fp_wb_t       fp_wb,
    input  bypass_pkg::reg_addr_t    int_rd_addr [bypass_pkg::int_read_ports],
    input  bypass_pkg::reg_addr_t    fp_rd_addr [bypass_pkg::fp_read_ports],
    output bypass_pkg::int_operand_t int_operand [bypass_pkg::int_read_ports],
    output bypass_pkg::fp_operand_t  fp_operand [bypass_pkg::fp_read_ports]
);
    import bypass_pkg::*;

    logic   int_hit [int_read_ports];
    word_t  int_value [int_read_ports];
    logic   fp_hit [fp_read_ports];
    dword_t fp_value [fp_read_ports];

    // Integer class with hardwired x0
    operand_fetch #(
        .value_t      (word_t),
        .BYPASS_DEPTH (BYPASS_DEPTH),
        .READ_PORTS   (int_read_ports),
        .ZERO_REG     (1'b1)
    ) u_int_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .wb_en    (int_wb.valid),
        .wb_addr  (int_wb.addr),
        .wb_value (int_wb.value),
        .rd_addr  (int_rd_addr),
        .rd_hit   (int_hit),
        .rd_value (int_value)
    );

    // Floating-point class, f0 is an ordinary register
    operand_fetch #(
        .value_t      (dword_t),
        .BYPASS_DEPTH (BYPASS_DEPTH),
        .READ_PORTS   (fp_read_ports),
        .ZERO_REG     (1'b0)
    ) u_fp_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .wb_en    (fp_wb.valid),
        .wb_addr  (fp_wb.addr),
        .wb_value (fp_wb.value),
        .rd_addr  (fp_rd_addr),
        .rd_hit   (fp_hit),
        .rd_value (fp_value)
    );

    always_comb begin
        for (int p = 0; p < int_read_ports; p++) begin
            int_operand[p].hit   = int_hit[p];
            int_operand[p].value = int_value[p];
        end
        for (int p = 0; p < fp_read_ports; p++) begin
            fp_operand[p].hit   = fp_hit[p];
            fp_operand[p].value = fp_value[p];
        end
    end

endmodule

/* src/operand_fetch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand fetch for one register class
// Bypass pipeline in front of the register file, optional
// hardwired zero register, per-port operand select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module operand_fetch #(
    parameter type value_t      = logic [31:0],
    parameter int  BYPASS_DEPTH = 3,
    parameter int  READ_PORTS   = 2,
    parameter bit  ZERO_REG     = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  wb_en,
    input  bypass_pkg::reg_addr_t wb_addr,
    input  value_t                wb_value,
    input  bypass_pkg::reg_addr_t rd_addr [READ_PORTS],
    output logic                  rd_hit [READ_PORTS],
    output value_t                rd_value [READ_PORTS]
);
    import bypass_pkg::*;

    logic      cam_wr_en;
    logic      commit_en;
    reg_addr_t commit_addr;
    value_t    commit_value;
    logic      rf_wr_en;

    logic   cam_hit [READ_PORTS];
    value_t cam_value [READ_PORTS];
    value_t rf_value [READ_PORTS];

    // Writes to x0 never enter the pipeline
    assign cam_wr_en = wb_en && !(ZERO_REG && (wb_addr == '0));

    // Tail entry retires only on a shifting edge
    assign rf_wr_en = commit_en && !stall && !flush;

    bypass_cam #(
        .value_t      (value_t),
        .BYPASS_DEPTH (BYPASS_DEPTH),
        .READ_PORTS   (READ_PORTS)
    ) u_bypass_cam (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .stall        (stall),
        .wr_en        (cam_wr_en),
        .wr_addr      (wb_addr),
        .wr_value     (wb_value),
        .rd_addr      (rd_addr),
        .rd_hit       (cam_hit),
        .rd_value     (cam_value),
        .commit_en    (commit_en),
        .commit_addr  (commit_addr),
        .commit_value (commit_value)
    );

    reg_file #(
        .value_t    (value_t),
        .READ_PORTS (READ_PORTS)
    ) u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (rf_wr_en),
        .wr_addr  (commit_addr),
        .wr_value (commit_value),
        .rd_addr  (rd_addr),
        .rd_value (rf_value)
    );

    // Bypass overrides the register file
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_hit[p]   = cam_hit[p];
            rd_value[p] = cam_hit[p] ? cam_value[p] : rf_value[p];
        end
    end

    zero_reg_untouched: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ZERO_REG && rf_wr_en && (commit_addr == '0))
    ) else $error("operand_fetch: commit to hardwired zero register");

endmodule

/* src/reg_file.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// 32 entries, one synchronous write port and several
// combinational read ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module reg_file #(
    parameter type value_t    = logic [31:0],
    parameter int  READ_PORTS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  bypass_pkg::reg_addr_t wr_addr,
    input  value_t                wr_value,
    input  bypass_pkg::reg_addr_t rd_addr [READ_PORTS],
    output value_t                rd_value [READ_PORTS]
);
    import bypass_pkg::*;

    localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

    value_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_value;
        end
    end

    // Reads see the old contents during a write cycle
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_value[p] = regs[rd_addr[p]];
        end
    end

    wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("reg_file: write with unknown address");

endmodule

/* src/bypass_cam.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bypass pipeline with associative lookup
// Shifts recent results, finds the youngest match per read
// port and hands the last stage out for commit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module bypass_cam #(
    parameter type value_t      = logic [31:0],
    parameter int  BYPASS_DEPTH = 3,
    parameter int  READ_PORTS   = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  wr_en,
    input  bypass_pkg::reg_addr_t wr_addr,
    input  value_t                wr_value,
    input  bypass_pkg::reg_addr_t rd_addr [READ_PORTS],
    output logic                  rd_hit [READ_PORTS],
    output value_t                rd_value [READ_PORTS],
    output logic                  commit_en,
    output bypass_pkg::reg_addr_t commit_addr,
    output value_t                commit_value
);
    import bypass_pkg::*;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        value_t    value;
    } entry_t;

    entry_t pipe [BYPASS_DEPTH];

    logic shift_en;
    logic [BYPASS_DEPTH-1:0] match [READ_PORTS];

    assign shift_en = !flush && !stall;

    // Stage 0 takes the new write, older entries move towards the tail
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int s = 0; s < BYPASS_DEPTH; s++) begin
                pipe[s].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipe[0].valid <= wr_en;
            pipe[0].addr  <= wr_addr;
            pipe[0].value <= wr_value;
            for (int s = 1; s < BYPASS_DEPTH; s++) begin
                pipe[s] <= pipe[s-1];
            end
        end
    end

    // Address match against every valid stage
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            for (int s = 0; s < BYPASS_DEPTH; s++) begin
                match[p][s] = pipe[s].valid && (pipe[s].addr == rd_addr[p]);
            end
        end
    end

    // Lowest matching stage is the youngest write
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_hit[p]   = |match[p];
            rd_value[p] = '0;
            for (int s = BYPASS_DEPTH - 1; s >= 0; s--) begin
                if (match[p][s]) begin
                    rd_value[p] = pipe[s].value;
                end
            end
        end
    end

    // Tail entry leaves towards the register file
    assign commit_en    = pipe[BYPASS_DEPTH-1].valid;
    assign commit_addr  = pipe[BYPASS_DEPTH-1].addr;
    assign commit_value = pipe[BYPASS_DEPTH-1].value;

    wr_en_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(wr_en)
    ) else $error("bypass_cam: wr_en is unknown");

    // A tail entry can only appear through a shifting edge
    commit_from_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(commit_en) |-> $past(shift_en && rst_n)
    ) else $error("bypass_cam: commit entry loaded without a shift");

endmodule

/* src/bypass_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bypass network shared types
// Register address, value widths, write-back and operand
// records for the integer and floating-point classes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bypass_pkg;

    // 32 architectural registers per class
    typedef logic [4:0] reg_addr_t;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // Integer result write-back
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     value;
    } int_wb_t;

    // Floating-point result write-back
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        dword_t    value;
    } fp_wb_t;

    // Hit is set when the value came from the bypass pipeline
    typedef struct packed {
        logic  hit;
        word_t value;
    } int_operand_t;

    typedef struct packed {
        logic   hit;
        dword_t value;
    } fp_operand_t;

    // Read ports per class
    localparam int int_read_ports = 2;
    localparam int fp_read_ports  = 3;

endpackage
